// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= pipeline.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
`default_nettype none

module alu #(
  parameter int rob_depth = 8
) (
  input  wire                          clock,
  input  wire                          arst_n,
  input  wire                          go,
  input  wire pip_pkg::alu_op_t        op,
  input  wire [pip_pkg::xlen-1:0]      a,
  input  wire [pip_pkg::xlen-1:0]      b,
  input  wire [$clog2(rob_depth)-1:0]  slot,
  output logic                         wr_valid,
  output logic [$clog2(rob_depth)-1:0] wr_slot,
  output logic [pip_pkg::xlen-1:0]     wr_data
);

  logic [pip_pkg::xlen-1:0] result;

  always_comb begin
    result = '0;
    case (op)
      pip_pkg::add:    result = a + b;
      pip_pkg::sub:    result = a - b;
      pip_pkg::and_op: result = a & b;
      pip_pkg::or_op:  result = a | b;
      pip_pkg::xor_op: result = a ^ b;
      pip_pkg::sll:    result = a << b[4:0];
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= go;
    end
  end

  always_ff @(posedge clock) begin
    if (go) begin
      wr_slot <= slot;
      wr_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== circ_buf.sv ====
`default_nettype none

module circ_buf #(
  parameter int iq_depth  = 8,
  parameter int rob_depth = 8
) (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire                             push,
  input  wire pip_pkg::alu_op_t           op,
  input  wire [pip_pkg::reg_addr_w-1:0]   rs1,
  input  wire [pip_pkg::reg_addr_w-1:0]   rs2,
  input  wire [pip_pkg::xlen-1:0]         imm,
  input  wire                             use_imm,
  input  wire [$clog2(rob_depth)-1:0]     rob_slot,
  input  wire                             pop,
  output logic                            full,
  output logic                            head_valid,
  output pip_pkg::alu_op_t                head_op,
  output logic [pip_pkg::reg_addr_w-1:0]  head_rs1,
  output logic [pip_pkg::reg_addr_w-1:0]  head_rs2,
  output logic [pip_pkg::xlen-1:0]        head_imm,
  output logic                            head_use_imm,
  output logic [$clog2(rob_depth)-1:0]    head_rob_slot
);

  localparam int ptr_w = $clog2(iq_depth);

  pip_pkg::alu_op_t               op_mem   [iq_depth];
  logic [pip_pkg::reg_addr_w-1:0] rs1_mem  [iq_depth];
  logic [pip_pkg::reg_addr_w-1:0] rs2_mem  [iq_depth];
  logic [pip_pkg::xlen-1:0]       imm_mem  [iq_depth];
  logic                           uimm_mem [iq_depth];
  logic [$clog2(rob_depth)-1:0]   slot_mem [iq_depth];
  logic [ptr_w-1:0]               wr_ptr;
  logic [ptr_w-1:0]               rd_ptr;
  logic [ptr_w:0]                 count;

  assign full       = (count == (ptr_w+1)'(iq_depth));
  assign head_valid = (count != '0);

  assign head_op       = op_mem[rd_ptr];
  assign head_rs1      = rs1_mem[rd_ptr];
  assign head_rs2      = rs2_mem[rd_ptr];
  assign head_imm      = imm_mem[rd_ptr];
  assign head_use_imm  = uimm_mem[rd_ptr];
  assign head_rob_slot = slot_mem[rd_ptr];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (ptr_w+1)'(push) - (ptr_w+1)'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      op_mem[wr_ptr]   <= op;
      rs1_mem[wr_ptr]  <= rs1;
      rs2_mem[wr_ptr]  <= rs2;
      imm_mem[wr_ptr]  <= imm;
      uimm_mem[wr_ptr] <= use_imm;
      slot_mem[wr_ptr] <= rob_slot;
    end
  end

  // Decode honours full, issue only pops a valid head
  assert property (@(posedge clock) disable iff (!arst_n)
    !(push && full) && !(pop && !head_valid));

endmodule

`default_nettype wire

// ==== decode.sv ====
`default_nettype none

module decode #(
  parameter int rob_depth = 8
) (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire [pip_pkg::xlen-1:0]         inst_word,
  input  wire                             inst_valid,
  input  wire                             rob_full,
  input  wire                             iq_full,
  input  wire [$clog2(rob_depth)-1:0]     alloc_slot,
  output logic                            stall,
  output logic                            reserve,
  output logic [pip_pkg::reg_addr_w-1:0]  dest_reg,
  output logic                            dest_valid,
  output logic                            push,
  output pip_pkg::alu_op_t                op,
  output logic [pip_pkg::reg_addr_w-1:0]  rs1,
  output logic [pip_pkg::reg_addr_w-1:0]  rs2,
  output logic [pip_pkg::xlen-1:0]        imm,
  output logic                            use_imm,
  output logic [$clog2(rob_depth)-1:0]    rob_slot
);

  logic [pip_pkg::xlen-1:0] word_q;
  logic                     held_q;
  logic                     send;
  logic [2:0]               funct3;

  assign send     = held_q & ~rob_full & ~iq_full;
  // Keep fetch off until the held slot is sure to be free
  assign stall    = inst_valid | (held_q & ~send);
  assign push     = send;
  assign reserve  = send;
  assign rob_slot = alloc_slot;
  assign funct3   = word_q[14:12];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      held_q <= 1'b0;
    end else if (inst_valid) begin
      held_q <= 1'b1;
    end else if (send) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      word_q <= inst_word;
    end
  end

  always_comb begin
    op       = pip_pkg::add;
    rs1      = word_q[19:15];
    rs2      = word_q[24:20];
    imm      = {{(pip_pkg::xlen-12){word_q[31]}}, word_q[31:20]};
    use_imm  = 1'b1;
    dest_reg = word_q[11:7];
    case (pip_pkg::opcode_t'(word_q[6:0]))
      pip_pkg::op_reg: begin
        use_imm = 1'b0;
        case (funct3)
          3'b000:  op = word_q[30] ? pip_pkg::sub : pip_pkg::add;
          3'b001:  op = pip_pkg::sll;
          3'b100:  op = pip_pkg::xor_op;
          3'b110:  op = pip_pkg::or_op;
          3'b111:  op = pip_pkg::and_op;
          default: dest_reg = '0;
        endcase
      end
      pip_pkg::op_imm: begin
        if (funct3 != 3'b000) begin
          dest_reg = '0;
        end
      end
      // Anything else becomes ADDI x0
      default: begin
        rs1      = '0;
        dest_reg = '0;
      end
    endcase
  end

  assign dest_valid = (dest_reg != '0);

endmodule

`default_nettype wire

// ==== ifetch.sv ====
`default_nettype none

module ifetch (
  input  wire                     clock,
  input  wire                     arst_n,
  input  wire                     stall,
  input  wire                     icache_waitrequest,
  input  wire [pip_pkg::xlen-1:0] icache_data,
  output logic [pip_pkg::xlen-1:0] icache_addr,
  output logic                    icache_rd,
  output logic [pip_pkg::xlen-1:0] inst_word,
  output logic                    inst_valid
);

  logic rd_en_q;
  logic accept;

  assign icache_rd = rd_en_q & ~stall;
  assign accept    = icache_rd & ~icache_waitrequest;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_en_q     <= 1'b0;
      icache_addr <= '0;
      inst_valid  <= 1'b0;
    end else begin
      rd_en_q    <= 1'b1;
      inst_valid <= accept;
      if (accept) begin
        icache_addr <= icache_addr + pip_pkg::xlen'(4);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      inst_word <= icache_data;
    end
  end

  // Request and address held while the bus stretches the request
  assert property (@(posedge clock) disable iff (!arst_n)
    icache_rd && icache_waitrequest |=> icache_rd && $stable(icache_addr));

endmodule

`default_nettype wire

// ==== issue.sv ====
`default_nettype none

module issue #(
  parameter int rob_depth = 8
) (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire                             head_valid,
  input  wire pip_pkg::alu_op_t           op,
  input  wire [pip_pkg::reg_addr_w-1:0]   rs1,
  input  wire [pip_pkg::reg_addr_w-1:0]   rs2,
  input  wire [pip_pkg::xlen-1:0]         imm,
  input  wire                             use_imm,
  input  wire [$clog2(rob_depth)-1:0]     rob_slot,
  output logic                            pop,
  output logic [pip_pkg::reg_addr_w-1:0]  a_reg,
  output logic [pip_pkg::reg_addr_w-1:0]  b_reg,
  input  wire                             a_hit,
  input  wire                             a_ready,
  input  wire [pip_pkg::xlen-1:0]         a_val,
  input  wire                             b_hit,
  input  wire                             b_ready,
  input  wire [pip_pkg::xlen-1:0]         b_val,
  output logic [pip_pkg::reg_addr_w-1:0]  rd_addr_a,
  output logic [pip_pkg::reg_addr_w-1:0]  rd_addr_b,
  input  wire [pip_pkg::xlen-1:0]         rd_data_a,
  input  wire [pip_pkg::xlen-1:0]         rd_data_b,
  output logic                            go,
  output pip_pkg::alu_op_t                alu_op,
  output logic [pip_pkg::xlen-1:0]        a,
  output logic [pip_pkg::xlen-1:0]        b,
  output logic [$clog2(rob_depth)-1:0]    slot
);

  logic a_wait;
  logic b_wait;

  assign a_reg     = rs1;
  assign b_reg     = rs2;
  assign rd_addr_a = rs1;
  assign rd_addr_b = rs2;

  // Pending writer in the ROB blocks issue
  assign a_wait = a_hit & ~a_ready;
  assign b_wait = ~use_imm & b_hit & ~b_ready;

  assign go     = head_valid & ~a_wait & ~b_wait;
  assign pop    = go;
  assign alu_op = op;
  assign slot   = rob_slot;
  assign a      = a_hit ? a_val : rd_data_a;
  assign b      = use_imm ? imm : (b_hit ? b_val : rd_data_b);

  // A stalled head stays put until it issues
  assert property (@(posedge clock) disable iff (!arst_n)
    head_valid && !go |=> head_valid && slot == $past(slot));

endmodule

`default_nettype wire

// ==== pip_pkg.sv ====
`default_nettype none

package pip_pkg;

  // Data and address width
  localparam int xlen = 32;

  // Register index width
  localparam int reg_addr_w = 5;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg = 7'b0110011,
    op_imm = 7'b0010011
  } opcode_t;

  typedef enum logic [2:0] {
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    sll
  } alu_op_t;

endpackage

`default_nettype wire

// ==== pipeline.f ====
pip_pkg.sv
ifetch.sv
decode.sv
circ_buf.sv
issue.sv
alu.sv
rob.sv
rfile.sv
pipeline.sv
tb_pipeline.sv

// ==== pipeline.sv ====
`default_nettype none

module pipeline #(
  parameter int rob_depth = 8,
  parameter int iq_depth  = 8
) (
  input  wire                             clock,
  input  wire                             arst_n,
  output wire [pip_pkg::xlen-1:0]         icache_addr,
  output wire                             icache_rd,
  input  wire [pip_pkg::xlen-1:0]         icache_data,
  input  wire                             icache_waitrequest,
  output wire                             retire_valid,
  output wire [pip_pkg::reg_addr_w-1:0]   retire_reg,
  output wire [pip_pkg::xlen-1:0]         retire_data
);

  localparam int slot_w = $clog2(rob_depth);
  localparam int rw     = pip_pkg::reg_addr_w;
  localparam int xw     = pip_pkg::xlen;

  // Fetch and decode
  logic [xw-1:0]     if_word;
  logic              if_valid;
  logic              dec_stall;
  logic              dec_reserve;
  logic [rw-1:0]     dec_dest_reg;
  logic              dec_dest_valid;
  logic              dec_push;
  pip_pkg::alu_op_t  dec_op;
  logic [rw-1:0]     dec_rs1;
  logic [rw-1:0]     dec_rs2;
  logic [xw-1:0]     dec_imm;
  logic              dec_use_imm;
  logic [slot_w-1:0] dec_rob_slot;

  // Issue queue head
  logic              iq_full;
  logic              iq_head_valid;
  pip_pkg::alu_op_t  iq_op;
  logic [rw-1:0]     iq_rs1;
  logic [rw-1:0]     iq_rs2;
  logic [xw-1:0]     iq_imm;
  logic              iq_use_imm;
  logic [slot_w-1:0] iq_rob_slot;

  // Issue and operand lookup
  logic              iss_pop;
  logic [rw-1:0]     iss_a_reg;
  logic [rw-1:0]     iss_b_reg;
  logic [rw-1:0]     iss_rd_addr_a;
  logic [rw-1:0]     iss_rd_addr_b;
  logic              iss_go;
  pip_pkg::alu_op_t  iss_alu_op;
  logic [xw-1:0]     iss_a;
  logic [xw-1:0]     iss_b;
  logic [slot_w-1:0] iss_slot;
  logic [xw-1:0]     rf_rd_data_a;
  logic [xw-1:0]     rf_rd_data_b;

  // ALU and ROB
  logic              alu_wr_valid;
  logic [slot_w-1:0] alu_wr_slot;
  logic [xw-1:0]     alu_wr_data;
  logic [slot_w-1:0] rob_alloc_slot;
  logic              rob_full;
  logic              rob_a_hit;
  logic              rob_a_ready;
  logic [xw-1:0]     rob_a_val;
  logic              rob_b_hit;
  logic              rob_b_ready;
  logic [xw-1:0]     rob_b_val;
  logic              rob_rf_wr_en;
  logic [rw-1:0]     rob_rf_wr_addr;
  logic [xw-1:0]     rob_rf_wr_data;

  ifetch ifetch_i (
    .clock              (clock),
    .arst_n             (arst_n),
    .stall              (dec_stall),
    .icache_waitrequest (icache_waitrequest),
    .icache_data        (icache_data),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .inst_word          (if_word),
    .inst_valid         (if_valid)
  );

  decode #(.rob_depth(rob_depth)) decode_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst_word  (if_word),
    .inst_valid (if_valid),
    .rob_full   (rob_full),
    .iq_full    (iq_full),
    .alloc_slot (rob_alloc_slot),
    .stall      (dec_stall),
    .reserve    (dec_reserve),
    .dest_reg   (dec_dest_reg),
    .dest_valid (dec_dest_valid),
    .push       (dec_push),
    .op         (dec_op),
    .rs1        (dec_rs1),
    .rs2        (dec_rs2),
    .imm        (dec_imm),
    .use_imm    (dec_use_imm),
    .rob_slot   (dec_rob_slot)
  );

  circ_buf #(.iq_depth(iq_depth), .rob_depth(rob_depth)) circ_buf_i (
    .clock         (clock),
    .arst_n        (arst_n),
    .push          (dec_push),
    .op            (dec_op),
    .rs1           (dec_rs1),
    .rs2           (dec_rs2),
    .imm           (dec_imm),
    .use_imm       (dec_use_imm),
    .rob_slot      (dec_rob_slot),
    .pop           (iss_pop),
    .full          (iq_full),
    .head_valid    (iq_head_valid),
    .head_op       (iq_op),
    .head_rs1      (iq_rs1),
    .head_rs2      (iq_rs2),
    .head_imm      (iq_imm),
    .head_use_imm  (iq_use_imm),
    .head_rob_slot (iq_rob_slot)
  );

  issue #(.rob_depth(rob_depth)) issue_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .head_valid (iq_head_valid),
    .op         (iq_op),
    .rs1        (iq_rs1),
    .rs2        (iq_rs2),
    .imm        (iq_imm),
    .use_imm    (iq_use_imm),
    .rob_slot   (iq_rob_slot),
    .pop        (iss_pop),
    .a_reg      (iss_a_reg),
    .b_reg      (iss_b_reg),
    .a_hit      (rob_a_hit),
    .a_ready    (rob_a_ready),
    .a_val      (rob_a_val),
    .b_hit      (rob_b_hit),
    .b_ready    (rob_b_ready),
    .b_val      (rob_b_val),
    .rd_addr_a  (iss_rd_addr_a),
    .rd_addr_b  (iss_rd_addr_b),
    .rd_data_a  (rf_rd_data_a),
    .rd_data_b  (rf_rd_data_b),
    .go         (iss_go),
    .alu_op     (iss_alu_op),
    .a          (iss_a),
    .b          (iss_b),
    .slot       (iss_slot)
  );

  alu #(.rob_depth(rob_depth)) alu_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .go       (iss_go),
    .op       (iss_alu_op),
    .a        (iss_a),
    .b        (iss_b),
    .slot     (iss_slot),
    .wr_valid (alu_wr_valid),
    .wr_slot  (alu_wr_slot),
    .wr_data  (alu_wr_data)
  );

  rob #(.rob_depth(rob_depth)) rob_i (
    .clock        (clock),
    .arst_n       (arst_n),
    .reserve      (dec_reserve),
    .dest_reg     (dec_dest_reg),
    .dest_valid   (dec_dest_valid),
    .alloc_slot   (rob_alloc_slot),
    .full         (rob_full),
    .wr_valid     (alu_wr_valid),
    .wr_slot      (alu_wr_slot),
    .wr_data      (alu_wr_data),
    .a_reg        (iss_a_reg),
    .b_reg        (iss_b_reg),
    .a_hit        (rob_a_hit),
    .a_ready      (rob_a_ready),
    .a_val        (rob_a_val),
    .b_hit        (rob_b_hit),
    .b_ready      (rob_b_ready),
    .b_val        (rob_b_val),
    .rf_wr_en     (rob_rf_wr_en),
    .rf_wr_addr   (rob_rf_wr_addr),
    .rf_wr_data   (rob_rf_wr_data),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

  rfile rfile_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .rd_addr_a (iss_rd_addr_a),
    .rd_addr_b (iss_rd_addr_b),
    .rd_data_a (rf_rd_data_a),
    .rd_data_b (rf_rd_data_b),
    .wr_en     (rob_rf_wr_en),
    .wr_addr   (rob_rf_wr_addr),
    .wr_data   (rob_rf_wr_data)
  );

endmodule

`default_nettype wire

// ==== pipeline_tests.txt ====
# test <name> starts a test, its program is placed from address 0
# <instruction hex> <retire reg, 0 when nothing retires> <retire data hex>
test alu_ops
00C00093 1 0000000C
00A00113 2 0000000A
002081B3 3 00000016
40208233 4 00000002
0020F2B3 5 00000008
0020E333 6 0000000E
0020C3B3 7 00000006
00209433 8 00003000
FFB08493 9 00000007
test dep_chain
00100093 1 00000001
001080B3 1 00000002
001080B3 1 00000004
001080B3 1 00000008
40100133 2 FFFFFFF8
001141B3 3 FFFFFFF0
00119233 4 FFFFF000
7FF20293 5 FFFFF7FF
test x0_writes
00500013 0 00000000
00300093 1 00000003
00108033 0 00000000
000002B3 5 00000000
00700313 6 00000007
001063B3 7 00000003
test long_independent
10100093 1 00000101
10200113 2 00000102
10300193 3 00000103
10400213 4 00000104
10500293 5 00000105
10600313 6 00000106
10700393 7 00000107
10800413 8 00000108
10900493 9 00000109
10A00513 10 0000010A
10B00593 11 0000010B
10C00613 12 0000010C

// ==== rfile.sv ====
`default_nettype none

module rfile (
  input  wire                            clock,
  input  wire                            arst_n,
  input  wire [pip_pkg::reg_addr_w-1:0]  rd_addr_a,
  input  wire [pip_pkg::reg_addr_w-1:0]  rd_addr_b,
  output logic [pip_pkg::xlen-1:0]       rd_data_a,
  output logic [pip_pkg::xlen-1:0]       rd_data_b,
  input  wire                            wr_en,
  input  wire [pip_pkg::reg_addr_w-1:0]  wr_addr,
  input  wire [pip_pkg::xlen-1:0]        wr_data
);

  localparam int nregs = 2 ** pip_pkg::reg_addr_w;

  logic [pip_pkg::xlen-1:0] regs [nregs];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== rob.sv ====
`default_nettype none

module rob #(
  parameter int rob_depth = 8
) (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire                             reserve,
  input  wire [pip_pkg::reg_addr_w-1:0]   dest_reg,
  input  wire                             dest_valid,
  output logic [$clog2(rob_depth)-1:0]    alloc_slot,
  output logic                            full,
  input  wire                             wr_valid,
  input  wire [$clog2(rob_depth)-1:0]     wr_slot,
  input  wire [pip_pkg::xlen-1:0]         wr_data,
  input  wire [pip_pkg::reg_addr_w-1:0]   a_reg,
  input  wire [pip_pkg::reg_addr_w-1:0]   b_reg,
  output logic                            a_hit,
  output logic                            a_ready,
  output logic [pip_pkg::xlen-1:0]        a_val,
  output logic                            b_hit,
  output logic                            b_ready,
  output logic [pip_pkg::xlen-1:0]        b_val,
  output logic                            rf_wr_en,
  output logic [pip_pkg::reg_addr_w-1:0]  rf_wr_addr,
  output logic [pip_pkg::xlen-1:0]        rf_wr_data,
  output logic                            retire_valid,
  output logic [pip_pkg::reg_addr_w-1:0]  retire_reg,
  output logic [pip_pkg::xlen-1:0]        retire_data
);

  localparam int idx_w = $clog2(rob_depth);

  logic [pip_pkg::reg_addr_w-1:0] dest_mem [rob_depth];
  logic                           dv_mem   [rob_depth];
  logic [pip_pkg::xlen-1:0]       val_mem  [rob_depth];
  logic [rob_depth-1:0]           ready_q;
  logic [idx_w-1:0]               head_q;
  logic [idx_w-1:0]               tail_q;
  logic [idx_w-1:0]               wr_age;
  logic [idx_w:0]                 count_q;
  logic                           retire;

  // Walk oldest to youngest so the last match wins
  // The youngest entry is the instruction now at issue and never its own source
  function automatic logic [pip_pkg::xlen+1:0] lookup(
    input logic [pip_pkg::reg_addr_w-1:0] r
  );
    logic [pip_pkg::xlen+1:0] res;
    logic [idx_w-1:0]         idx;
    res = '0;
    for (int i = 0; i < rob_depth; i++) begin
      idx = head_q + idx_w'(i);
      if ((idx_w+1)'(i + 1) < count_q && dv_mem[idx] && dest_mem[idx] == r) begin
        res = {1'b1, ready_q[idx], val_mem[idx]};
      end
    end
    return res;
  endfunction

  always_comb begin
    {a_hit, a_ready, a_val} = lookup(a_reg);
    {b_hit, b_ready, b_val} = lookup(b_reg);
  end

  assign alloc_slot = tail_q;
  assign full       = (count_q == (idx_w+1)'(rob_depth));

  // Ready head retires and x0 writers leave without a pulse
  assign retire       = (count_q != '0) && ready_q[head_q];
  assign retire_valid = retire & dv_mem[head_q];
  assign retire_reg   = dest_mem[head_q];
  assign retire_data  = val_mem[head_q];
  assign rf_wr_en     = retire_valid;
  assign rf_wr_addr   = retire_reg;
  assign rf_wr_data   = retire_data;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      ready_q <= '0;
    end else begin
      if (reserve) begin
        tail_q          <= tail_q + 1'b1;
        ready_q[tail_q] <= 1'b0;
      end
      if (wr_valid) begin
        ready_q[wr_slot] <= 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + (idx_w+1)'(reserve) - (idx_w+1)'(retire);
    end
  end

  always_ff @(posedge clock) begin
    if (reserve) begin
      dest_mem[tail_q] <= dest_reg;
      dv_mem[tail_q]   <= dest_valid;
    end
    if (wr_valid) begin
      val_mem[wr_slot] <= wr_data;
    end
  end

  assign wr_age = wr_slot - head_q;

  // ALU results only land on live, still pending slots
  assert property (@(posedge clock) disable iff (!arst_n)
    wr_valid |-> ({1'b0, wr_age} < count_q) && !ready_q[wr_slot]);

endmodule

`default_nettype wire

// ==== tb_pipeline.sv ====
`default_nettype none

module tb_pipeline;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int rob_depth = 8;
  localparam int iq_depth  = 8;
  localparam logic [31:0] nop_word = 32'h0000_0013;

  logic        clock;
  logic        arst_n;
  logic [31:0] icache_addr;
  logic        icache_rd;
  logic [31:0] icache_data;
  logic        icache_waitrequest;
  logic        retire_valid;
  logic [4:0]  retire_reg;
  logic [31:0] retire_data;

  // Whole test file, one entry per instruction
  string       test_name [$];
  int          test_first [$];
  int          test_len [$];
  logic [31:0] prog_word [$];
  logic [4:0]  prog_reg [$];
  logic [31:0] prog_data [$];

  // Retire events expected from the running test
  logic [4:0]  exp_reg [$];
  logic [31:0] exp_data [$];

  string       cur_name;
  int          cur_first;
  int          cur_len;
  bit          running;
  bit          loaded;
  int          got;
  logic [31:0] next_addr;
  logic [31:0] lfsr;
  int          main_checks;
  int          main_errors;
  int          mon_checks;
  int          mon_errors;
  longint      watchdog_ns;

  pipeline #(.rob_depth(rob_depth), .iq_depth(iq_depth)) dut_i (
    .clock              (clock),
    .arst_n             (arst_n),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .retire_valid       (retire_valid),
    .retire_reg         (retire_reg),
    .retire_data        (retire_data)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // No-ops past the end of the program
  function automatic logic [31:0] program_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (addr[1:0] != 2'b00 || idx >= cur_len) begin
      return nop_word;
    end
    return prog_word[cur_first + idx];
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    mon_checks++;
    if (actual !== expected) begin
      mon_errors++;
      $display("ERR %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    int          rd;
    int          k;
    string       line;
    string       kw;
    string       name;
    logic [31:0] word;
    logic [31:0] data;
    fd = $fopen("pipeline_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open pipeline_tests.txt");
      main_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if ($sscanf(line, "%s", kw) == 1 && kw.substr(0, 0) != "#") begin
        if (kw == "test") begin
          n = $sscanf(line, "%s %s", kw, name);
          test_name.push_back(name);
          test_first.push_back(prog_word.size());
          test_len.push_back(0);
        end else if ($sscanf(line, "%h %d %h", word, rd, data) == 3 &&
                     test_len.size() > 0) begin
          prog_word.push_back(word);
          prog_reg.push_back(5'(rd));
          prog_data.push_back(data);
          k = test_len.size() - 1;
          test_len[k] = test_len[k] + 1;
        end else begin
          $display("Unreadable line in pipeline_tests.txt: %s", line);
          main_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #1;
    arst_n = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic run_test(input int t);
    cur_name  = test_name[t];
    cur_first = test_first[t];
    cur_len   = test_len[t];
    exp_reg.delete();
    exp_data.delete();
    for (int i = 0; i < cur_len; i++) begin
      if (prog_reg[cur_first + i] != 5'd0) begin
        exp_reg.push_back(prog_reg[cur_first + i]);
        exp_data.push_back(prog_data[cur_first + i]);
      end
    end
    running = 1'b0;
    apply_reset();
    #1;
    main_checks++;
    if (retire_valid !== 1'b0 || icache_rd !== 1'b0 || icache_addr !== 32'd0) begin
      main_errors++;
      $display("%s: outputs not idle after reset (retire_valid %b, icache_rd %b, addr %h)",
               cur_name, retire_valid, icache_rd, icache_addr);
    end
    running = 1'b1;
    while (got < exp_reg.size()) begin
      @(posedge clock);
    end
    // Trailing no-ops must stay silent
    repeat (20) @(posedge clock);
    running = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Instruction bus model
  initial begin
    icache_waitrequest = 1'b1;
    icache_data        = nop_word;
    lfsr               = 32'h1b66;
    forever begin
      @(posedge clock);
      #1;
      lfsr               = lfsr_step(lfsr);
      icache_waitrequest = lfsr[0];
      icache_data        = program_word(icache_addr);
    end
  end

  // Fetch order and retire trace, sampled mid cycle
  initial begin
    got        = 0;
    next_addr  = '0;
    mon_checks = 0;
    mon_errors = 0;
    forever begin
      @(negedge clock);
      if (!arst_n) begin
        got       = 0;
        next_addr = '0;
      end else if (running) begin
        if (icache_rd && !icache_waitrequest) begin
          check_value("fetch address", next_addr, icache_addr);
          next_addr = next_addr + 32'd4;
        end
        if (retire_valid) begin
          if (got >= exp_reg.size()) begin
            mon_errors++;
            $display("%s: x%0d retired after the last expected result", cur_name, retire_reg);
          end else begin
            check_value($sformatf("retire %0d reg", got), {27'd0, exp_reg[got]},
                        {27'd0, retire_reg});
            check_value($sformatf("retire %0d data", got), exp_data[got], retire_data);
          end
          got++;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns with test %s still running", watchdog_ns, cur_name);
    $display("Checks %0d, errors %0d", main_checks + mon_checks, main_errors + mon_errors + 1);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    arst_n      = 1'b0;
    running     = 1'b0;
    loaded      = 1'b0;
    cur_name    = "none";
    cur_first   = 0;
    cur_len     = 0;
    main_checks = 0;
    main_errors = 0;
    load_tests();
    if (test_name.size() == 0) begin
      $display("No tests were read from pipeline_tests.txt");
      main_errors++;
    end
    watchdog_ns = 100 * (longint'(prog_word.size()) * 24 + longint'(test_name.size()) * 80 + 20);
    loaded = 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("Checks %0d, errors %0d", main_checks + mon_checks, main_errors + mon_errors);
    if (main_errors + mon_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
